// File: all.f
+incdir+include
verilog/rasterix_pkg.sv
verilog/rasterix_if.sv
verilog/cmd_decoder.sv
verilog/depth_test.sv
verilog/frame_buffer.sv
verilog/frame_streamer.sv
verilog/rasterix_fb_top.sv
verif/rasterix_fb_sva.sv
verif/rasterix_fb_tb.sv

// File: include/rasterix_config.svh
// Framebuffer configuration
`ifndef RASTERIX_CONFIG_SVH
`define RASTERIX_CONFIG_SVH

// Screen geometry
`define RX_X_WIDTH          4
`define RX_Y_WIDTH          3
`define RX_X_RES            16
`define RX_Y_RES            8
`define RX_ADDR_WIDTH       7

// Pixel formats
`define RX_SUB_PIXEL_WIDTH  6
`define RX_DEPTH_WIDTH      16

// Streams and command fields
`define RX_CMD_WIDTH        32
`define RX_BUF_ADDR_WIDTH   24
`define RX_OPCODE_LSB       28

`endif

// File: run.sh
#!/bin/sh
# Build and run the framebuffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module rasterix_fb_tb -o rasterix_fb_sim

out=$(./obj_dir/rasterix_fb_sim || true)
echo "$out"
echo "$out" | grep -q '^>>> PASS$'

// File: verif/rasterix_fb_sva.sv
// Stream and swap protocol checks
`timescale 1ns/1ps
`include "rasterix_config.svh"

module rasterix_fb_sva
(
    input logic                     aclk,
    input logic                     reset,
    input logic                     swap_fb,
    input logic                     m_framebuffer_axis_tvalid,
    input logic                     m_framebuffer_axis_tready,
    input logic                     m_framebuffer_axis_tlast,
    input logic [`RX_CMD_WIDTH-1:0] m_framebuffer_axis_tdata
);
    // A swap request is a single-cycle pulse
    swap_pulse: assert property (@(posedge aclk) disable iff (reset)
        swap_fb |=> !swap_fb)
        else $error("swap_fb stayed high for more than one cycle");

    // A stalled beat keeps its payload
    hold_under_stall: assert property (@(posedge aclk) disable iff (reset)
        m_framebuffer_axis_tvalid && !m_framebuffer_axis_tready
        |=> m_framebuffer_axis_tvalid && $stable(m_framebuffer_axis_tdata)
            && $stable(m_framebuffer_axis_tlast))
        else $error("Output beat changed or dropped while stalled");

    idle_after_reset: assert property (@(posedge aclk)
        reset |=> !m_framebuffer_axis_tvalid)
        else $error("Output stream valid right after reset");
endmodule

bind rasterix_fb_top rasterix_fb_sva rasterix_fb_sva_i (.*);

// File: verif/rasterix_fb_tb.sv
// Framebuffer testbench
`timescale 1ns/1ps
`include "rasterix_config.svh"

module rasterix_fb_tb
    import rasterix_pkg::*;
();
    localparam int N_TESTS         = 20;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int N_PIX           = `RX_X_RES * `RX_Y_RES;
    localparam int N_BEATS         = N_PIX / 2;

    logic                          aclk = 1'b0;
    logic                          reset;
    logic                          s_cmd_axis_tvalid;
    logic                          s_cmd_axis_tready;
    logic                          s_cmd_axis_tlast;
    logic [`RX_CMD_WIDTH-1:0]      s_cmd_axis_tdata;
    logic                          m_framebuffer_axis_tvalid;
    logic                          m_framebuffer_axis_tready = 1'b1;
    logic                          m_framebuffer_axis_tlast;
    logic [`RX_CMD_WIDTH-1:0]      m_framebuffer_axis_tdata;
    logic                          swap_fb;
    logic [`RX_BUF_ADDR_WIDTH-1:0] fb_addr;
    logic                          fb_swapped;
    logic                          bp_en = 1'b0;

    // Reference framebuffer and configuration
    logic [17:0] ref_color [N_PIX];
    logic [15:0] ref_depth [N_PIX];
    logic        m_sc_en;
    int          m_sx0;
    int          m_sy0;
    int          m_sx1;
    int          m_sy1;
    logic        m_dt_en;
    logic        m_dmask;
    logic [2:0]  m_cmask;
    logic [17:0] m_clear_color;
    logic [15:0] m_clear_depth;

    string test_name = "reset";
    int    seq_errors = 0;
    int    seq_checks = 0;
    int    stream_errors = 0;
    int    stream_checks = 0;
    int    beat_idx = 0;
    int    frames_done = 0;
    int    last_frame_beats = 0;

    always #5 aclk = ~aclk;

    rasterix_fb_top rasterix_fb_top_i (.*);

    function automatic logic [15:0] pack_rgb565(input logic [17:0] c);
        return {c[17:13], c[11:6], c[5:1]};
    endfunction

    // Expected beat with the even pixel in the low half
    function automatic logic [31:0] ref_frame(input int beat);
        return {pack_rgb565(ref_color[2*beat+1]), pack_rgb565(ref_color[2*beat])};
    endfunction

    function automatic logic inside_scissor(input int x, input int y);
        return !m_sc_en || (x >= m_sx0 && x < m_sx1 && y >= m_sy0 && y < m_sy1);
    endfunction

    // r, g, b lanes follow mask bits 2, 1, 0
    function automatic logic [17:0] masked_color(input logic [17:0] old_c,
                                                 input logic [17:0] new_c);
        logic [17:0] res;
        res = old_c;
        if (m_cmask[2])
            res[17:12] = new_c[17:12];
        if (m_cmask[1])
            res[11:6] = new_c[11:6];
        if (m_cmask[0])
            res[5:0] = new_c[5:0];
        return res;
    endfunction

    function automatic logic [31:0] make_cmd(input opcode_t op, input logic [27:0] payload);
        return {op, payload};
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        seq_checks++;
        assert (exp === act)
        else
        begin
            seq_errors++;
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // Returns on the edge where the beat transfers while tvalid is still high
    task automatic send_cmd(input logic [31:0] word);
        @(negedge aclk);
        s_cmd_axis_tvalid = 1'b1;
        s_cmd_axis_tdata  = word;
        while (!s_cmd_axis_tready)
            @(negedge aclk);
        @(posedge aclk);
    endtask

    task automatic bus_idle();
        @(negedge aclk);
        s_cmd_axis_tvalid = 1'b0;
    endtask

    task automatic wait_ready();
        while (!s_cmd_axis_tready)
            @(negedge aclk);
    endtask

    // Lets in-flight pixels land before the configuration changes
    task automatic drain_pixels();
        bus_idle();
        repeat (3) @(negedge aclk);
    endtask

    task automatic set_conf(input logic sc, input logic dt, input logic dm,
                            input logic [2:0] cm);
        drain_pixels();
        send_cmd(make_cmd(OP_CONF, {21'b0, cm, 1'b0, dm, dt, sc}));
        bus_idle();
        m_sc_en = sc;
        m_dt_en = dt;
        m_dmask = dm;
        m_cmask = cm;
    endtask

    task automatic set_scissor(input int x0, input int y0, input int x1, input int y1);
        drain_pixels();
        send_cmd(make_cmd(OP_SCISSOR_START, {16'b0, 4'(y0), 3'b0, 5'(x0)}));
        send_cmd(make_cmd(OP_SCISSOR_END, {16'b0, 4'(y1), 3'b0, 5'(x1)}));
        bus_idle();
        m_sx0 = x0;
        m_sy0 = y0;
        m_sx1 = x1;
        m_sy1 = y1;
    endtask

    task automatic set_clear(input logic [17:0] c, input logic [15:0] d);
        send_cmd(make_cmd(OP_CLEAR_COLOR, {10'b0, c}));
        send_cmd(make_cmd(OP_CLEAR_DEPTH, {12'b0, d}));
        bus_idle();
        m_clear_color = c;
        m_clear_depth = d;
    endtask

    task automatic do_memset(input logic c, input logic d);
        send_cmd(make_cmd(OP_MEMSET, {26'b0, d, c}));
        bus_idle();
        wait_ready();
        for (int a = 0; a < N_PIX; a++)
        begin
            if (inside_scissor(a % 16, a / 16))
            begin
                if (c)
                    ref_color[a] = masked_color(ref_color[a], m_clear_color);
                if (d && m_dmask)
                    ref_depth[a] = m_clear_depth;
            end
        end
    endtask

    task automatic write_pixel(input int x, input int y, input logic [15:0] d,
                               input logic [17:0] c);
        int a;
        a = y * 16 + x;
        send_cmd(make_cmd(OP_PIXEL, {1'b0, 3'(y), 4'b0, 4'(x), d}));
        send_cmd({14'b0, c});
        if ((!m_dt_en || d < ref_depth[a]) && inside_scissor(x, y))
        begin
            ref_color[a] = masked_color(ref_color[a], c);
            if (m_dmask)
                ref_depth[a] = d;
        end
    endtask

    // Every fourth pixel is followed at once by another on the same address
    task automatic random_pixels(input int count);
        int x;
        int y;
        for (int i = 0; i < count; i++)
        begin
            x = int'($urandom % 16);
            y = int'($urandom % 8);
            write_pixel(x, y, 16'($urandom), 18'($urandom));
            if (i % 4 == 0)
                write_pixel(x, y, 16'($urandom), 18'($urandom));
        end
        drain_pixels();
    endtask

    task automatic do_commit();
        int frames_before;
        frames_before = frames_done;
        send_cmd(make_cmd(OP_COMMIT, 28'b0));
        bus_idle();
        wait_ready();
        check_value("frames", frames_before + 1, frames_done);
        check_value("beats per frame", N_BEATS, last_frame_beats);
    endtask

    task automatic do_swap(input logic [23:0] addr);
        int delay;
        delay = 2 + int'($urandom % 16);
        send_cmd(make_cmd(OP_SWAP, {4'b0, addr}));
        bus_idle();
        check_value("swap_fb", 1, swap_fb);
        check_value("fb_addr", addr, fb_addr);
        @(negedge aclk);
        check_value("swap_fb after pulse", 0, swap_fb);
        // Offer a NOP that must wait for fb_swapped
        s_cmd_axis_tvalid = 1'b1;
        s_cmd_axis_tdata  = make_cmd(OP_NOP, 28'b0);
        repeat (delay)
        begin
            check_value("tready during swap", 0, s_cmd_axis_tready);
            @(negedge aclk);
        end
        fb_swapped = 1'b1;
        @(negedge aclk);
        fb_swapped = 1'b0;
        check_value("tready after swap", 1, s_cmd_axis_tready);
        @(posedge aclk);
        bus_idle();
    endtask

    // Random sink back-pressure
    always @(negedge aclk)
        m_framebuffer_axis_tready = bp_en ? 1'($urandom % 2) : 1'b1;

    // Output stream comparison
    always @(posedge aclk)
    begin
        if (!reset && m_framebuffer_axis_tvalid && m_framebuffer_axis_tready)
        begin
            stream_checks++;
            assert (m_framebuffer_axis_tdata === ref_frame(beat_idx % N_BEATS))
            else
            begin
                stream_errors++;
                $display("[FAIL] %s: beat %0d expected %h actual %h", test_name, beat_idx,
                         ref_frame(beat_idx % N_BEATS), m_framebuffer_axis_tdata);
            end
            assert (m_framebuffer_axis_tlast === (beat_idx == N_BEATS - 1))
            else
            begin
                stream_errors++;
                $display("[FAIL] %s: tlast on beat %0d expected %0d actual %0d", test_name,
                         beat_idx, beat_idx == N_BEATS - 1, m_framebuffer_axis_tlast);
            end
            if (m_framebuffer_axis_tlast)
            begin
                last_frame_beats = beat_idx + 1;
                frames_done++;
                beat_idx = 0;
            end
            else
                beat_idx++;
        end
    end

    initial
    begin
        repeat (N_TESTS * CYCLES_PER_TEST) @(posedge aclk);
        $display("Watchdog expired in %s, the DUT stopped responding", test_name);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(13));
        reset             = 1'b1;
        s_cmd_axis_tvalid = 1'b0;
        s_cmd_axis_tlast  = 1'b0;
        s_cmd_axis_tdata  = '0;
        fb_swapped        = 1'b0;
        m_sc_en           = 1'b0;
        m_sx0             = 0;
        m_sy0             = 0;
        m_sx1             = 0;
        m_sy1             = 0;
        m_dt_en           = 1'b0;
        m_dmask           = 1'b1;
        m_cmask           = 3'b111;
        m_clear_color     = '0;
        m_clear_depth     = '0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        test_name = "memset_clear";
        set_clear(18'($urandom), 16'hc000);
        do_memset(1'b1, 1'b1);
        do_commit();

        test_name = "depth_pixels";
        set_conf(1'b0, 1'b1, 1'b1, 3'b111);
        random_pixels(40);
        do_commit();

        test_name = "scissor_memset";
        set_scissor(3, 2, 11, 6);
        set_conf(1'b1, 1'b0, 1'b1, 3'b111);
        set_clear(18'($urandom), 16'h4000);
        do_memset(1'b1, 1'b0);
        do_commit();
        random_pixels(12);
        set_scissor(14, 7, 16, 8);
        set_clear(18'($urandom), 16'h4000);
        do_memset(1'b1, 1'b1);
        do_commit();

        test_name = "write_masks";
        set_conf(1'b0, 1'b0, 1'b1, 3'b101);
        set_clear(18'($urandom), 16'h2000);
        do_memset(1'b1, 1'b0);
        random_pixels(10);
        set_conf(1'b0, 1'b0, 1'b0, 3'b011);
        random_pixels(10);
        do_memset(1'b0, 1'b1);
        set_conf(1'b0, 1'b1, 1'b1, 3'b111);
        random_pixels(16);
        do_commit();

        test_name = "backpressure";
        bp_en = 1'b1;
        do_commit();
        bp_en = 1'b0;
        do_commit();

        test_name = "swap";
        do_swap(24'($urandom));
        do_swap(24'($urandom));
        do_commit();

        $display("Checks %0d, stream errors %0d, sequence errors %0d",
                 stream_checks + seq_checks, stream_errors, seq_errors);
        if (stream_errors == 0 && seq_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verilog/cmd_decoder.sv
// Command decoder
`timescale 1ns/1ps
`include "rasterix_config.svh"

module cmd_decoder
    import rasterix_pkg::*;
(
    input  logic                          aclk,
    input  logic                          reset,

    input  logic                          s_cmd_axis_tvalid,
    output logic                          s_cmd_axis_tready,
    input  logic                          s_cmd_axis_tlast,
    input  logic [`RX_CMD_WIDTH-1:0]      s_cmd_axis_tdata,

    output logic                          color_memset_start,
    output logic                          depth_memset_start,
    input  logic                          color_memset_busy,
    input  logic                          depth_memset_busy,
    output color_t                        clear_color,
    output depth_t                        clear_depth,
    output logic [2:0]                    color_mask,
    output logic                          depth_mask,
    output logic                          depth_test_en,

    output logic                          commit_start,
    input  logic                          commit_done,

    output logic                          swap_fb,
    output logic [`RX_BUF_ADDR_WIDTH-1:0] fb_addr,
    input  logic                          fb_swapped,

    fb_conf_if.src                        conf,
    pixel_if.src                          pix
);
    dec_state_t state;
    opcode_t    opcode;
    logic       beat;
    logic       memset_running;

    // Commands frame themselves by opcode, s_cmd_axis_tlast carries nothing
    assign beat   = s_cmd_axis_tvalid && s_cmd_axis_tready;
    assign opcode = opcode_t'(s_cmd_axis_tdata[`RX_OPCODE_LSB +: 4]);
    assign s_cmd_axis_tready = (state == ST_IDLE) || (state == ST_PIXEL_COLOR);

    // Start pulses count as running, busy only rises a cycle later
    assign memset_running = color_memset_start || depth_memset_start
                         || color_memset_busy || depth_memset_busy;

    always_ff @(posedge aclk)
    begin
        color_memset_start <= 1'b0;
        depth_memset_start <= 1'b0;
        commit_start       <= 1'b0;
        swap_fb            <= 1'b0;
        pix.valid          <= 1'b0;
        if (reset)
        begin
            state                <= ST_IDLE;
            conf.scissor_en      <= 1'b0;
            conf.scissor_start_x <= '0;
            conf.scissor_start_y <= '0;
            conf.scissor_end_x   <= '0;
            conf.scissor_end_y   <= '0;
            depth_test_en        <= 1'b0;
            depth_mask           <= 1'b1;
            color_mask           <= 3'b111;
            clear_color          <= '0;
            clear_depth          <= '0;
            fb_addr              <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (beat)
                    begin
                        case (opcode)
                            OP_SCISSOR_START:
                            begin
                                conf.scissor_start_x <= s_cmd_axis_tdata[4:0];
                                conf.scissor_start_y <= s_cmd_axis_tdata[11:8];
                            end
                            OP_SCISSOR_END:
                            begin
                                conf.scissor_end_x <= s_cmd_axis_tdata[4:0];
                                conf.scissor_end_y <= s_cmd_axis_tdata[11:8];
                            end
                            OP_CONF:
                            begin
                                conf.scissor_en <= s_cmd_axis_tdata[0];
                                depth_test_en   <= s_cmd_axis_tdata[1];
                                depth_mask      <= s_cmd_axis_tdata[2];
                                color_mask      <= s_cmd_axis_tdata[6:4];
                            end
                            OP_CLEAR_COLOR: clear_color <= s_cmd_axis_tdata[17:0];
                            OP_CLEAR_DEPTH: clear_depth <= s_cmd_axis_tdata[15:0];
                            OP_MEMSET:
                            begin
                                color_memset_start <= s_cmd_axis_tdata[0];
                                depth_memset_start <= s_cmd_axis_tdata[1];
                                if (|s_cmd_axis_tdata[1:0])
                                    state <= ST_MEMSET;
                            end
                            OP_PIXEL: state <= ST_PIXEL_COLOR;
                            OP_COMMIT:
                            begin
                                commit_start <= 1'b1;
                                state        <= ST_COMMIT;
                            end
                            OP_SWAP:
                            begin
                                swap_fb <= 1'b1;
                                fb_addr <= s_cmd_axis_tdata[`RX_BUF_ADDR_WIDTH-1:0];
                                state   <= ST_SWAP;
                            end
                            default: ;
                        endcase
                    end
                ST_PIXEL_COLOR:
                    if (beat)
                    begin
                        pix.valid <= 1'b1;
                        state     <= ST_IDLE;
                    end
                ST_MEMSET:
                    if (!memset_running)
                        state <= ST_IDLE;
                ST_COMMIT:
                    if (commit_done)
                        state <= ST_IDLE;
                ST_SWAP:
                    if (fb_swapped)
                        state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Pixel payload, held until the pulse after the color beat
    always_ff @(posedge aclk)
    begin
        if (beat && (state == ST_IDLE) && (opcode == OP_PIXEL))
        begin
            pix.depth <= s_cmd_axis_tdata[15:0];
            pix.x     <= s_cmd_axis_tdata[19:16];
            pix.y     <= s_cmd_axis_tdata[26:24];
        end
        if (beat && (state == ST_PIXEL_COLOR))
            pix.color <= s_cmd_axis_tdata[17:0];
    end

endmodule

// File: verilog/depth_test.sv
// Depth test pipeline
`timescale 1ns/1ps
`include "rasterix_config.svh"

module depth_test
    import rasterix_pkg::*;
(
    input  logic                     aclk,
    input  logic                     reset,
    input  logic                     depth_test_en,
    pixel_if.dst                     pix,

    output logic [`RX_ADDR_WIDTH-1:0] depth_raddr,
    input  depth_t                   depth_rdata,

    output logic                     wvalid,
    output logic [`RX_X_WIDTH-1:0]   wx,
    output logic [`RX_Y_WIDTH-1:0]   wy,
    output color_t                   wcolor,
    output depth_t                   wdepth
);
    logic   s2_valid;
    logic   fwd_valid;
    depth_t fwd_depth;
    depth_t stored_depth;

    // Stage 1 reads the stored depth
    assign depth_raddr = {pix.y, pix.x};

    // Stage 2, memory reads old data when both stages hit one address
    assign stored_depth = fwd_valid ? fwd_depth : depth_rdata;
    assign wvalid = s2_valid && (!depth_test_en || (wdepth < stored_depth));

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            s2_valid  <= 1'b0;
            fwd_valid <= 1'b0;
        end
        else
        begin
            s2_valid  <= pix.valid;
            fwd_valid <= pix.valid && wvalid && ({wy, wx} == depth_raddr);
        end
    end

    always_ff @(posedge aclk)
    begin
        wx        <= pix.x;
        wy        <= pix.y;
        wdepth    <= pix.depth;
        wcolor    <= pix.color;
        fwd_depth <= wdepth;
    end

endmodule

// File: verilog/frame_buffer.sv
// Scissored pixel memory
`timescale 1ns/1ps
`include "rasterix_config.svh"

module frame_buffer
    import rasterix_pkg::*;
#(
    parameter int PIXEL_WIDTH = 18,
    parameter int MASK_WIDTH  = 3
)
(
    input  logic                      aclk,
    input  logic                      reset,
    fb_conf_if.dst                    conf,

    input  logic                      wvalid,
    input  logic [`RX_X_WIDTH-1:0]    wx,
    input  logic [`RX_Y_WIDTH-1:0]    wy,
    input  logic [PIXEL_WIDTH-1:0]    wdata,
    input  logic [MASK_WIDTH-1:0]     wmask,

    input  logic [PIXEL_WIDTH-1:0]    clear_value,
    input  logic                      memset_start,
    output logic                      memset_busy,

    input  logic [`RX_ADDR_WIDTH-1:0] raddr,
    output logic [PIXEL_WIDTH-1:0]    rdata
);
    localparam int LANE_WIDTH = PIXEL_WIDTH / MASK_WIDTH;
    localparam int DEPTH      = `RX_X_RES * `RX_Y_RES;

    logic [PIXEL_WIDTH-1:0]    mem [DEPTH];
    logic [`RX_ADDR_WIDTH-1:0] sweep_addr;
    logic [`RX_ADDR_WIDTH-1:0] waddr;
    logic [PIXEL_WIDTH-1:0]    data;
    screen_x_t                 px;
    screen_y_t                 py;
    logic                      in_scissor;
    logic                      wen;

    // Sweep owns the write port while it runs
    assign waddr = memset_busy ? sweep_addr : {wy, wx};
    assign data  = memset_busy ? clear_value : wdata;

    assign px = {1'b0, waddr[`RX_X_WIDTH-1:0]};
    assign py = {1'b0, waddr[`RX_ADDR_WIDTH-1:`RX_X_WIDTH]};

    // Start inclusive, end exclusive
    assign in_scissor = !conf.scissor_en
                     || ((px >= conf.scissor_start_x) && (px < conf.scissor_end_x)
                      && (py >= conf.scissor_start_y) && (py < conf.scissor_end_y));
    assign wen = (memset_busy || wvalid) && in_scissor;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            memset_busy <= 1'b0;
            sweep_addr  <= '0;
        end
        else if (memset_start)
        begin
            memset_busy <= 1'b1;
            sweep_addr  <= '0;
        end
        else if (memset_busy)
        begin
            sweep_addr <= sweep_addr + 1'b1;
            if (&sweep_addr)
                memset_busy <= 1'b0;
        end
    end

    // One mask bit per lane
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < MASK_WIDTH; i++)
        begin
            if (wen && wmask[i])
                mem[waddr][i*LANE_WIDTH +: LANE_WIDTH] <= data[i*LANE_WIDTH +: LANE_WIDTH];
        end
        rdata <= mem[raddr];
    end

endmodule

// File: verilog/frame_streamer.sv
// RGB565 framebuffer streamer
`timescale 1ns/1ps
`include "rasterix_config.svh"

module frame_streamer
    import rasterix_pkg::*;
(
    input  logic                      aclk,
    input  logic                      reset,
    input  logic                      commit_start,
    output logic                      commit_done,

    output logic [`RX_ADDR_WIDTH-1:0] raddr,
    input  color_t                    rdata,

    output logic                      m_framebuffer_axis_tvalid,
    input  logic                      m_framebuffer_axis_tready,
    output logic                      m_framebuffer_axis_tlast,
    output logic [`RX_CMD_WIDTH-1:0]  m_framebuffer_axis_tdata
);
    logic                      rd_valid;
    logic [`RX_ADDR_WIDTH-1:0] cur;
    logic                      out_free;
    logic                      take;
    logic [15:0]               lo_pix;

    function automatic logic [15:0] to_rgb565(input color_t c);
        to_rgb565 = {c.r[5:1], c.g, c.b[5:1]};
    endfunction

    assign out_free = !m_framebuffer_axis_tvalid || m_framebuffer_axis_tready;

    // Even pixels park in lo_pix, odd ones need a free output register
    assign take = rd_valid && (!cur[0] || out_free);

    // A pixel that cannot be taken is read again
    always_comb
    begin
        if (rd_valid && !take)
            raddr = cur;
        else if (rd_valid)
            raddr = cur + 1'b1;
        else
            raddr = '0;
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            rd_valid                  <= 1'b0;
            m_framebuffer_axis_tvalid <= 1'b0;
            m_framebuffer_axis_tlast  <= 1'b0;
            commit_done               <= 1'b0;
        end
        else
        begin
            commit_done <= m_framebuffer_axis_tvalid && m_framebuffer_axis_tready
                        && m_framebuffer_axis_tlast;
            if (commit_start)
                rd_valid <= 1'b1;
            else if (take && (&cur))
                rd_valid <= 1'b0;

            if (take && cur[0])
            begin
                m_framebuffer_axis_tvalid <= 1'b1;
                m_framebuffer_axis_tlast  <= &cur;
            end
            else if (m_framebuffer_axis_tready)
            begin
                m_framebuffer_axis_tvalid <= 1'b0;
                m_framebuffer_axis_tlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (commit_start)
            cur <= '0;
        else if (take)
            cur <= cur + 1'b1;
        if (take && !cur[0])
            lo_pix <= to_rgb565(rdata);
        if (take && cur[0])
            m_framebuffer_axis_tdata <= {to_rgb565(rdata), lo_pix};
    end

endmodule

// File: verilog/rasterix_fb_top.sv
// Framebuffer top level
`timescale 1ns/1ps
`include "rasterix_config.svh"

module rasterix_fb_top
    import rasterix_pkg::*;
(
    input  logic                          aclk,
    input  logic                          reset,

    input  logic                          s_cmd_axis_tvalid,
    output logic                          s_cmd_axis_tready,
    input  logic                          s_cmd_axis_tlast,
    input  logic [`RX_CMD_WIDTH-1:0]      s_cmd_axis_tdata,

    output logic                          m_framebuffer_axis_tvalid,
    input  logic                          m_framebuffer_axis_tready,
    output logic                          m_framebuffer_axis_tlast,
    output logic [`RX_CMD_WIDTH-1:0]      m_framebuffer_axis_tdata,

    output logic                          swap_fb,
    output logic [`RX_BUF_ADDR_WIDTH-1:0] fb_addr,
    input  logic                          fb_swapped
);
    logic                      color_memset_start;
    logic                      depth_memset_start;
    logic                      color_memset_busy;
    logic                      depth_memset_busy;
    color_t                    clear_color;
    depth_t                    clear_depth;
    logic [2:0]                color_mask;
    logic                      depth_mask;
    logic                      depth_test_en;
    logic                      commit_start;
    logic                      commit_done;
    logic [`RX_ADDR_WIDTH-1:0] depth_raddr;
    depth_t                    depth_rdata;
    logic [`RX_ADDR_WIDTH-1:0] color_raddr;
    color_t                    color_rdata;
    logic                      wvalid;
    logic [`RX_X_WIDTH-1:0]    wx;
    logic [`RX_Y_WIDTH-1:0]    wy;
    color_t                    wcolor;
    depth_t                    wdepth;

    fb_conf_if conf ();
    pixel_if   pix ();

    cmd_decoder cmd_decoder_i (.*);

    depth_test depth_test_i (
        .aclk, .reset, .depth_test_en, .pix,
        .depth_raddr, .depth_rdata,
        .wvalid, .wx, .wy, .wcolor, .wdepth
    );

    frame_buffer #(
        .PIXEL_WIDTH ($bits(color_t)),
        .MASK_WIDTH  (3)
    ) color_buffer (
        .aclk, .reset, .conf, .wvalid, .wx, .wy,
        .wdata        (wcolor),
        .wmask        (color_mask),
        .clear_value  (clear_color),
        .memset_start (color_memset_start),
        .memset_busy  (color_memset_busy),
        .raddr        (color_raddr),
        .rdata        (color_rdata)
    );

    frame_buffer #(
        .PIXEL_WIDTH (`RX_DEPTH_WIDTH),
        .MASK_WIDTH  (1)
    ) depth_buffer (
        .aclk, .reset, .conf, .wvalid, .wx, .wy,
        .wdata        (wdepth),
        .wmask        (depth_mask),
        .clear_value  (clear_depth),
        .memset_start (depth_memset_start),
        .memset_busy  (depth_memset_busy),
        .raddr        (depth_raddr),
        .rdata        (depth_rdata)
    );

    frame_streamer frame_streamer_i (
        .aclk, .reset, .commit_start, .commit_done,
        .raddr (color_raddr),
        .rdata (color_rdata),
        .m_framebuffer_axis_tvalid,
        .m_framebuffer_axis_tready,
        .m_framebuffer_axis_tlast,
        .m_framebuffer_axis_tdata
    );

endmodule

// File: verilog/rasterix_if.sv
// Framebuffer interfaces
`timescale 1ns/1ps
`include "rasterix_config.svh"

// Scissor rectangle shared by both buffers
interface fb_conf_if
    import rasterix_pkg::*;
();
    logic      scissor_en;
    screen_x_t scissor_start_x;
    screen_y_t scissor_start_y;
    screen_x_t scissor_end_x;
    screen_y_t scissor_end_y;

    modport src (
        output scissor_en, scissor_start_x, scissor_start_y, scissor_end_x, scissor_end_y
    );

    modport dst (
        input  scissor_en, scissor_start_x, scissor_start_y, scissor_end_x, scissor_end_y
    );
endinterface

// One pixel per valid pulse, never stalled
interface pixel_if
    import rasterix_pkg::*;
();
    logic                   valid;
    logic [`RX_X_WIDTH-1:0] x;
    logic [`RX_Y_WIDTH-1:0] y;
    depth_t                 depth;
    color_t                 color;

    modport src (output valid, x, y, depth, color);
    modport dst (input  valid, x, y, depth, color);
endinterface

// File: verilog/rasterix_pkg.sv
// Framebuffer types
`include "rasterix_config.svh"

package rasterix_pkg;

    typedef enum logic [3:0] {
        OP_NOP           = 4'd0,
        OP_SCISSOR_START = 4'd1,
        OP_SCISSOR_END   = 4'd2,
        OP_CONF          = 4'd3,
        OP_CLEAR_COLOR   = 4'd4,
        OP_CLEAR_DEPTH   = 4'd5,
        OP_MEMSET        = 4'd6,
        OP_PIXEL         = 4'd7,
        OP_COMMIT        = 4'd8,
        OP_SWAP          = 4'd9
    } opcode_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PIXEL_COLOR,
        ST_MEMSET,
        ST_COMMIT,
        ST_SWAP
    } dec_state_t;

    typedef struct packed {
        logic [`RX_SUB_PIXEL_WIDTH-1:0] r;
        logic [`RX_SUB_PIXEL_WIDTH-1:0] g;
        logic [`RX_SUB_PIXEL_WIDTH-1:0] b;
    } color_t;

    typedef logic [`RX_DEPTH_WIDTH-1:0] depth_t;

    // One bit wider than the coordinate so the exclusive end fits
    typedef logic [`RX_X_WIDTH:0] screen_x_t;
    typedef logic [`RX_Y_WIDTH:0] screen_y_t;

endpackage
